/* vlog.f */
hw/flash_cmd_pkg.sv
hw/flash_buf_pkg.sv
hw/sync_2stage.sv
hw/bitser_wbuf.sv
hw/bitser_rbuf.sv
hw/spi_flash_seq.sv
hw/spi_flash_intf.sv
testbench/flash_model.sv
testbench/tb_spi_flash.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the flash port testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_spi_flash -o tb_sim > build.log 2>&1 \
    || { echo "compile failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "simulation exited with an error, see sim.log"; exit 1; }

grep -q "RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* testbench/tb_spi_flash.sv */
`timescale 1ns/1ps

module tb_spi_flash;

    localparam int BS_BITS = 200;

    logic        clk;
    logic        ipb_clk;
    logic        bit_cnt_reset;
    logic        flash_cmd_strobe;
    logic [31:0] flash_cmd;
    logic        wbuf_wr_en;
    logic [6:0]  wbuf_wr_addr;
    logic [31:0] wbuf_data_in;
    logic        rbuf_rd_en;
    logic [6:0]  rbuf_rd_addr;
    logic [31:0] rbuf_data_out;
    logic        read_bitstream;
    logic        busy;
    logic        bs_data;
    logic        bs_valid;
    logic        end_bitstream;
    logic        spi_clk;
    logic        spi_mosi;
    logic        spi_ss;
    logic        spi_miso;

    int          errors = 0;
    int          tests  = 0;
    int          failed = 0;
    int          seed   = 32'h6671_3566;
    logic [31:0] wshadow [4];          // host copy of WBUF words 0..3
    logic        cnt_clear;
    int          vcnt;                 // bs_valid cycles since cnt_clear
    int          ecnt;                 // end_bitstream pulses since cnt_clear

    spi_flash_intf #(.BS_BITS(BS_BITS)) dut (
        .clk(clk), .ipb_clk(ipb_clk), .bit_cnt_reset(bit_cnt_reset),
        .flash_cmd_strobe(flash_cmd_strobe), .flash_cmd(flash_cmd),
        .wbuf_wr_en(wbuf_wr_en), .wbuf_wr_addr(wbuf_wr_addr), .wbuf_data_in(wbuf_data_in),
        .rbuf_rd_en(rbuf_rd_en), .rbuf_rd_addr(rbuf_rd_addr), .rbuf_data_out(rbuf_data_out),
        .read_bitstream(read_bitstream), .busy(busy), .bs_data(bs_data),
        .bs_valid(bs_valid), .end_bitstream(end_bitstream), .spi_clk(spi_clk),
        .spi_mosi(spi_mosi), .spi_ss(spi_ss), .spi_miso(spi_miso)
    );

    flash_model u_model (.spi_clk(spi_clk), .spi_ss(spi_ss), .spi_mosi(spi_mosi),
                         .spi_miso(spi_miso));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;          // 4 ns
    end

    initial begin
        ipb_clk = 1'b0;
        forever #1.5 ipb_clk = ~ipb_clk; // 3 ns host bus
    end

    // expected miso for spi_clk edge e, byte index XOR 0x5A, MSB first
    function automatic logic pattern_bit(input int e);
        logic [7:0] b;
        b = 8'(e / 8) ^ 8'h5A;
        return b[7 - (e % 8)];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        errors++;
        $display("FAILED %s expected %h got %h", name, exp, got);
    endtask

    always @(posedge clk) begin
        if (cnt_clear) begin
            vcnt <= 0;
            ecnt <= 0;
        end else begin
            if (bs_valid)      vcnt <= vcnt + 1;
            if (end_bitstream) ecnt <= ecnt + 1;
        end
    end

    // ============================================================
    // concurrent checks
    // ============================================================
    a_bs_data: assert property (@(posedge clk) disable iff (bit_cnt_reset)
        bs_valid |-> bs_data == pattern_bit(33 + vcnt))
        else report_mismatch("bs_data", 32'(pattern_bit(33 + $sampled(vcnt))),
                             32'($sampled(bs_data)));

    a_end_count: assert property (@(posedge clk) disable iff (bit_cnt_reset)
        end_bitstream |-> vcnt == BS_BITS)
        else report_mismatch("bs_valid count", 32'(BS_BITS), 32'($sampled(vcnt)));

    a_end_pulse: assert property (@(posedge clk) disable iff (bit_cnt_reset)
        end_bitstream |-> !$past(end_bitstream))
        else begin
            errors++;
            $display("end_bitstream stayed high for more than one cycle");
        end

    a_ss_idle: assert property (@(posedge clk) disable iff (bit_cnt_reset)
        !busy |-> spi_ss)
        else begin
            errors++;
            $display("spi_ss was low while the port was idle");
        end

    // ============================================================
    // host side tasks
    // ============================================================
    task automatic wbuf_write(input int addr, input logic [31:0] data);
        @(posedge ipb_clk);
        wbuf_wr_en   <= 1'b1;
        wbuf_wr_addr <= 7'(addr);
        wbuf_data_in <= data;
        @(posedge ipb_clk);
        wbuf_wr_en   <= 1'b0;
        if (addr < 4) wshadow[addr] = data;
    endtask

    task automatic fill_random;
        for (int w = 0; w < 4; w++) wbuf_write(w, $random(seed));
    endtask

    task automatic host_cmd(input flash_cmd_pkg::nbytes_t n, input flash_cmd_pkg::nbytes_t m);
        @(posedge ipb_clk);
        flash_cmd_strobe <= 1'b1;
        flash_cmd        <= {7'b0, n, 7'b0, m};   // 0x0NNN0MMM
        @(posedge ipb_clk);
        flash_cmd_strobe <= 1'b0;
    endtask

    task automatic wait_busy(input logic level, input int limit);
        int i;
        for (i = 0; i < limit; i++) begin
            @(negedge clk);
            if (busy == level) break;
        end
        if (i == limit) begin
            errors++;
            $display("timeout waiting for busy to become %0d", level);
        end
    endtask

    task automatic run_cmd(input flash_cmd_pkg::nbytes_t n, input flash_cmd_pkg::nbytes_t m);
        host_cmd(n, m);
        wait_busy(1'b1, 40);
        wait_busy(1'b0, 8 * (n + m) + 100);
    endtask

    task automatic check_mosi(input int nb);
        for (int b = 0; b < nb; b++) begin
            if (u_model.rx_bytes[b] !== wshadow[b / 4][31 - 8 * (b % 4) -: 8]) begin
                report_mismatch("spi_mosi byte", 32'(wshadow[b / 4][31 - 8 * (b % 4) -: 8]),
                                32'(u_model.rx_bytes[b]));
            end
        end
    endtask

    task automatic rbuf_read(input int addr, output logic [31:0] data);
        @(posedge ipb_clk);
        rbuf_rd_en   <= 1'b1;
        rbuf_rd_addr <= 7'(addr);
        @(posedge ipb_clk);             // word captured here
        rbuf_rd_en   <= 1'b0;
        @(negedge ipb_clk);
        data = rbuf_data_out;
    endtask

    // response bit j was edge 8N+1+j, only the first 8M bits are defined
    task automatic check_rbuf(input int n, input int m);
        logic [31:0] got;
        logic [31:0] exp;
        logic [31:0] mask;
        for (int w = 0; w < (8 * m + 31) / 32; w++) begin
            exp  = '0;
            mask = '0;
            for (int i = 0; i < 32; i++) begin
                if (32 * w + i < 8 * m) begin
                    exp[31 - i]  = pattern_bit(8 * n + 1 + 32 * w + i);
                    mask[31 - i] = 1'b1;
                end
            end
            rbuf_read(w, got);
            if ((got & mask) !== (exp & mask)) report_mismatch("rbuf_data_out", exp, got & mask);
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %0d %s: passed", tests, name);
        end else begin
            failed++;
            $display("test %0d %s: failed with %0d errors", tests, name, errors - err_before);
        end
    endtask

    // ============================================================
    // stimulus
    // ============================================================
    initial begin
        int e0;
        int n;
        int m;
        int i;
        bit bad;
        bit_cnt_reset    = 1'b1;
        flash_cmd_strobe = 1'b0;
        flash_cmd        = '0;
        wbuf_wr_en       = 1'b0;
        wbuf_wr_addr     = '0;
        wbuf_data_in     = '0;
        rbuf_rd_en       = 1'b0;
        rbuf_rd_addr     = '0;
        read_bitstream   = 1'b0;
        cnt_clear        = 1'b1;
        repeat (2) @(posedge clk);
        bit_cnt_reset <= 1'b0;
        cnt_clear     <= 1'b0;

        e0 = errors;                    // N=4, M=8
        fill_random();
        run_cmd(4, 8);
        check_mosi(4);
        check_rbuf(4, 8);
        end_test("command N=4 M=8", e0);

        e0 = errors;                    // no response, RBUF must keep test 1 data
        fill_random();                  // fresh bytes so stale model data cannot match
        run_cmd(2, 0);
        @(negedge clk);
        if (!spi_ss || busy) report_mismatch("spi_ss/busy", 32'h2, {30'b0, spi_ss, busy});
        check_mosi(2);
        check_rbuf(4, 8);
        end_test("command M=0", e0);

        e0 = errors;                    // N=0 is dropped
        host_cmd(0, 4);
        bad = 1'b0;
        repeat (50) begin
            @(negedge clk);
            if (busy || !spi_ss) bad = 1'b1;
        end
        if (bad) begin
            errors++;
            $display("port started a transfer for a command with zero bytes");
        end
        end_test("command N=0", e0);

        e0 = errors;                    // bitstream read
        fill_random();                  // new word 0 for the read command
        @(posedge clk);
        cnt_clear      <= 1'b1;
        @(posedge clk);
        cnt_clear      <= 1'b0;
        read_bitstream <= 1'b1;
        @(posedge clk);
        read_bitstream <= 1'b0;
        for (i = 0; i < BS_BITS + 100; i++) begin
            @(negedge clk);
            if (end_bitstream) break;
        end
        if (i == BS_BITS + 100) begin
            errors++;
            $display("timeout waiting for end_bitstream");
        end
        repeat (3) @(negedge clk);
        if (vcnt != BS_BITS) report_mismatch("bs_valid count", 32'(BS_BITS), 32'(vcnt));
        if (ecnt != 1) report_mismatch("end_bitstream count", 32'h1, 32'(ecnt));
        check_mosi(4);
        end_test("bitstream read", e0);

        e0 = errors;                    // random sizes
        repeat (5) begin
            n = 1 + int'($unsigned($random(seed)) % 16);
            m = int'($unsigned($random(seed)) % 17);
            fill_random();
            run_cmd(9'(n), 9'(m));
            check_mosi(n);
            check_rbuf(n, m);
        end
        end_test("random commands", e0);

        e0 = errors;                    // reset in the middle of SEND_CMD
        fill_random();
        host_cmd(8, 4);
        wait_busy(1'b1, 40);
        for (i = 0; i < 20; i++) begin
            @(negedge clk);
            if (!spi_ss) break;
        end
        if (i == 20) begin
            errors++;
            $display("timeout waiting for spi_ss to fall");
        end
        repeat (5) @(negedge clk);
        @(posedge clk);
        bit_cnt_reset <= 1'b1;
        @(posedge clk);
        bit_cnt_reset <= 1'b0;
        @(negedge clk);
        if (!spi_ss || busy) report_mismatch("spi_ss/busy", 32'h2, {30'b0, spi_ss, busy});
        run_cmd(3, 5);
        check_mosi(3);
        check_rbuf(3, 5);
        end_test("reset during send", e0);

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* testbench/flash_model.sv */
`timescale 1ns/1ps

module flash_model (
    input  logic spi_clk,
    input  logic spi_ss,
    input  logic spi_mosi,
    output logic spi_miso
);

    // ============================================================
    // behavioral serial flash
    // ============================================================
    // every byte seen on mosi since spi_ss fell, first byte at index 0
    logic [7:0]  rx_bytes [256];
    logic [10:0] edge_cnt = '0;        // spi_clk edges since spi_ss fell
    logic        miso_q   = 1'b0;

    // response byte p is p XOR 0x5A, sent MSB first
    function automatic logic miso_bit(input logic [10:0] e);
        logic [7:0] resp;
        resp = e[10:3] ^ 8'h5A;
        return resp[~e[2:0]];           // bit 0 of the byte goes out as bit 7
    endfunction

    // rising spi_clk is the falling edge of clk, mid bit
    always @(posedge spi_clk) begin
        if (spi_ss) begin
            edge_cnt <= '0;             // deselected, next transfer starts at edge 0
        end else begin
            rx_bytes[edge_cnt[10:3]][~edge_cnt[2:0]] <= spi_mosi;
            miso_q   <= miso_bit(edge_cnt);
            edge_cnt <= edge_cnt + 1'b1;
        end
    end

    assign spi_miso = miso_q;

endmodule

/* hw/spi_flash_intf.sv */
`timescale 1ns/1ps

module spi_flash_intf #(
    parameter int unsigned BS_BITS = 24090592
) (
    input  logic                              clk,
    input  logic                              ipb_clk,
    input  logic                              bit_cnt_reset,
    input  logic                              flash_cmd_strobe,
    input  logic [flash_buf_pkg::WORD_W-1:0]  flash_cmd,
    input  logic                              wbuf_wr_en,
    input  logic [flash_buf_pkg::WADDR_W-1:0] wbuf_wr_addr,
    input  logic [flash_buf_pkg::WORD_W-1:0]  wbuf_data_in,
    input  logic                              rbuf_rd_en,
    input  logic [flash_buf_pkg::WADDR_W-1:0] rbuf_rd_addr,
    output logic [flash_buf_pkg::WORD_W-1:0]  rbuf_data_out,
    input  logic                              read_bitstream,
    output logic                              busy,
    output logic                              bs_data,
    output logic                              bs_valid,
    output logic                              end_bitstream,
    output logic                              spi_clk,
    output logic                              spi_mosi,
    output logic                              spi_ss,
    input  logic                              spi_miso
);

    flash_cmd_pkg::flash_cmd_u cmd_q;           // last command word from the host
    logic                      cmd_tog = 1'b0;  // power-up value
    logic                      tog_s;
    logic                      tog_d;
    logic                      start_req;
    flash_cmd_pkg::nbytes_t    wr_nbytes;
    flash_cmd_pkg::nbytes_t    rd_nbytes;

    logic                              wbuf_rd_en;
    logic                              rbuf_wr_en;
    logic [flash_buf_pkg::BADDR_W-1:0] bit_addr;   // shared by both flash-side ports
    logic                              wbuf_bit;

    // ============================================================
    // command capture on ipb_clk
    // ============================================================
    always_ff @(posedge ipb_clk) begin
        if (flash_cmd_strobe) begin
            cmd_q.raw <= flash_cmd;
            cmd_tog   <= ~cmd_tog;      // one flip per command
        end
    end

    // ============================================================
    // crossing into clk
    // ============================================================
    sync_2stage #(.WIDTH(1)) u_tog_sync (
        .clk (clk),
        .in  (cmd_tog),
        .out (tog_s)
    );

    // counts stay put until busy falls, so plain two-flop sampling holds
    sync_2stage #(.WIDTH($bits(flash_cmd_pkg::nbytes_t))) u_wr_sync (
        .clk (clk),
        .in  (cmd_q.fields.wr_nbytes),
        .out (wr_nbytes)
    );

    sync_2stage #(.WIDTH($bits(flash_cmd_pkg::nbytes_t))) u_rd_sync (
        .clk (clk),
        .in  (cmd_q.fields.rd_nbytes),
        .out (rd_nbytes)
    );

    always_ff @(posedge clk) begin
        tog_d <= tog_s;
    end

    assign start_req = tog_s ^ tog_d;   // any edge is a new command

    // ============================================================
    // buffers and sequencer
    // ============================================================
    bitser_wbuf u_wbuf (
        .ipb_clk (ipb_clk),
        .wr_en   (wbuf_wr_en),
        .wr_addr (wbuf_wr_addr),
        .wr_data (wbuf_data_in),
        .clk     (clk),
        .rd_en   (wbuf_rd_en),
        .rd_addr (bit_addr),
        .rd_bit  (wbuf_bit)
    );

    bitser_rbuf u_rbuf (
        .clk     (clk),
        .wr_en   (rbuf_wr_en),
        .wr_addr (bit_addr),
        .wr_bit  (spi_miso),
        .ipb_clk (ipb_clk),
        .rd_en   (rbuf_rd_en),
        .rd_addr (rbuf_rd_addr),
        .rd_data (rbuf_data_out)
    );

    spi_flash_seq #(.BS_BITS(BS_BITS)) u_seq (
        .clk           (clk),
        .bit_cnt_reset (bit_cnt_reset),
        .start_req     (start_req),
        .bs_req        (read_bitstream),
        .wr_nbytes     (wr_nbytes),
        .rd_nbytes     (rd_nbytes),
        .wbuf_rd_en    (wbuf_rd_en),
        .rbuf_wr_en    (rbuf_wr_en),
        .bit_addr      (bit_addr),
        .spi_ss        (spi_ss),
        .busy          (busy),
        .bs_valid      (bs_valid),
        .end_bitstream (end_bitstream)
    );

    // flash samples on the rising spi_clk, in the middle of each bit
    assign spi_clk  = ~clk;
    assign spi_mosi = wbuf_bit;
    assign bs_data  = spi_miso;         // qualified by bs_valid

endmodule

/* hw/spi_flash_seq.sv */
`timescale 1ns/1ps

module spi_flash_seq #(
    parameter int unsigned BS_BITS = 24090592
) (
    input  logic                              clk,
    input  logic                              bit_cnt_reset,
    input  logic                              start_req,
    input  logic                              bs_req,
    input  flash_cmd_pkg::nbytes_t            wr_nbytes,
    input  flash_cmd_pkg::nbytes_t            rd_nbytes,
    output logic                              wbuf_rd_en,
    output logic                              rbuf_wr_en,
    output logic [flash_buf_pkg::BADDR_W-1:0] bit_addr,
    output logic                              spi_ss,
    output logic                              busy,
    output logic                              bs_valid,
    output logic                              end_bitstream
);

    localparam int BS_CNT_W = 25;       // holds BS_BITS up to 33.5M
    localparam logic [BS_CNT_W-1:0] BS_END = BS_CNT_W'(BS_BITS - 1);
    localparam logic [flash_buf_pkg::BADDR_W-1:0] BS_CMD_END = 31;   // 4 command bytes

    logic [flash_cmd_pkg::NUM_STATES-1:0] state;
    logic [flash_cmd_pkg::NUM_STATES-1:0] state_nxt;

    logic [flash_buf_pkg::BADDR_W-1:0] bit_cnt;
    logic [flash_buf_pkg::BADDR_W-1:0] wr_end;     // 8N-1
    logic [flash_buf_pkg::BADDR_W-1:0] rd_end;     // 8M-1
    logic [BS_CNT_W-1:0]               bs_cnt;
    logic                              cnt_clr;
    logic                              sending;

    // byte counts to last bit index, all ones when the count is zero
    assign wr_end = {wr_nbytes, 3'b000} - 1'b1;
    assign rd_end = {rd_nbytes, 3'b000} - 1'b1;

    // ============================================================
    // counters
    // ============================================================
    always_ff @(posedge clk) begin
        if (bit_cnt_reset || cnt_clr) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bit_cnt_reset || !state[flash_cmd_pkg::READ_BS]) begin
            bs_cnt <= '0;       // only runs while streaming
        end else begin
            bs_cnt <= bs_cnt + 1'b1;
        end
    end

    // ============================================================
    // state machine
    // ============================================================
    always_ff @(posedge clk) begin
        if (bit_cnt_reset) begin
            state                      <= '0;
            state[flash_cmd_pkg::IDLE] <= 1'b1;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = '0;
        case (1'b1)
            state[flash_cmd_pkg::IDLE]: begin
                // a command wins over a bitstream request, N = 0 is dropped
                if (start_req && (wr_nbytes != '0)) begin
                    state_nxt[flash_cmd_pkg::START_CMD] = 1'b1;
                end else if (bs_req) begin
                    state_nxt[flash_cmd_pkg::START_BS_CMD] = 1'b1;
                end else begin
                    state_nxt[flash_cmd_pkg::IDLE] = 1'b1;
                end
            end
            state[flash_cmd_pkg::START_CMD]: state_nxt[flash_cmd_pkg::SEND_CMD] = 1'b1;
            state[flash_cmd_pkg::SEND_CMD]: begin
                if (bit_cnt == wr_end) begin
                    state_nxt[flash_cmd_pkg::FINISH_CMD] = 1'b1;
                end else begin
                    state_nxt[flash_cmd_pkg::SEND_CMD] = 1'b1;
                end
            end
            state[flash_cmd_pkg::FINISH_CMD]: begin
                if (rd_nbytes == '0) begin
                    state_nxt[flash_cmd_pkg::IDLE] = 1'b1;    // nothing to read back
                end else begin
                    state_nxt[flash_cmd_pkg::RECEIVE_RSP] = 1'b1;
                end
            end
            state[flash_cmd_pkg::RECEIVE_RSP]: begin
                if (bit_cnt == rd_end) begin
                    state_nxt[flash_cmd_pkg::IDLE] = 1'b1;
                end else begin
                    state_nxt[flash_cmd_pkg::RECEIVE_RSP] = 1'b1;
                end
            end
            state[flash_cmd_pkg::START_BS_CMD]: state_nxt[flash_cmd_pkg::SEND_BS_CMD] = 1'b1;
            state[flash_cmd_pkg::SEND_BS_CMD]: begin
                if (bit_cnt == BS_CMD_END) begin
                    state_nxt[flash_cmd_pkg::FINISH_BS_CMD] = 1'b1;
                end else begin
                    state_nxt[flash_cmd_pkg::SEND_BS_CMD] = 1'b1;
                end
            end
            state[flash_cmd_pkg::FINISH_BS_CMD]: state_nxt[flash_cmd_pkg::READ_BS] = 1'b1;
            state[flash_cmd_pkg::READ_BS]: begin
                if (bs_cnt == BS_END) begin
                    state_nxt[flash_cmd_pkg::BS_DONE] = 1'b1;
                end else begin
                    state_nxt[flash_cmd_pkg::READ_BS] = 1'b1;
                end
            end
            state[flash_cmd_pkg::BS_DONE]: state_nxt[flash_cmd_pkg::IDLE] = 1'b1;
            default: state_nxt[flash_cmd_pkg::IDLE] = 1'b1;   // recover from a bad vector
        endcase
    end

    // ============================================================
    // outputs decoded from the state
    // ============================================================
    assign sending = state[flash_cmd_pkg::SEND_CMD] || state[flash_cmd_pkg::SEND_BS_CMD];

    // counter only runs while bits move in or out
    assign cnt_clr = !(sending || state[flash_cmd_pkg::RECEIVE_RSP]);

    assign wbuf_rd_en = sending || state[flash_cmd_pkg::START_CMD]
                                || state[flash_cmd_pkg::START_BS_CMD];
    assign rbuf_wr_en = state[flash_cmd_pkg::RECEIVE_RSP];

    // WBUF read is registered, so while sending fetch one bit ahead
    assign bit_addr = sending ? bit_cnt + 1'b1 : bit_cnt;

    assign spi_ss = state[flash_cmd_pkg::IDLE]         || state[flash_cmd_pkg::START_CMD]
                 || state[flash_cmd_pkg::START_BS_CMD] || state[flash_cmd_pkg::BS_DONE];

    assign busy          = !state[flash_cmd_pkg::IDLE];
    assign bs_valid      = state[flash_cmd_pkg::READ_BS];
    assign end_bitstream = state[flash_cmd_pkg::BS_DONE];     // single cycle

    // ============================================================
    // checks
    // ============================================================
    a_onehot: assert property (@(posedge clk) disable iff (bit_cnt_reset)
        $onehot(state));

    // deselected in IDLE and still for the START cycle that follows
    a_ss_idle: assert property (@(posedge clk) disable iff (bit_cnt_reset)
        state[flash_cmd_pkg::IDLE] |-> spi_ss ##1 spi_ss);

    a_cnt_bound: assert property (@(posedge clk) disable iff (bit_cnt_reset)
        (state[flash_cmd_pkg::SEND_CMD]    |-> bit_cnt <= wr_end) and
        (state[flash_cmd_pkg::RECEIVE_RSP] |-> bit_cnt <= rd_end) and
        (state[flash_cmd_pkg::SEND_BS_CMD] |-> bit_cnt <= BS_CMD_END));

endmodule

/* hw/bitser_rbuf.sv */
`timescale 1ns/1ps

module bitser_rbuf (
    input  logic                              clk,
    input  logic                              wr_en,
    input  logic [flash_buf_pkg::BADDR_W-1:0] wr_addr,
    input  logic                              wr_bit,
    input  logic                              ipb_clk,
    input  logic                              rd_en,
    input  logic [flash_buf_pkg::WADDR_W-1:0] rd_addr,
    output logic [flash_buf_pkg::WORD_W-1:0]  rd_data
);

    // bit address 32w+i sits in word w, bit i
    logic [flash_buf_pkg::WORD_W-1:0] mem [flash_buf_pkg::NUM_WORDS];
    logic [flash_buf_pkg::WORD_W-1:0] rd_word;     // raw word, first bit in bit 0

    // ============================================================
    // flash port
    // ============================================================
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr[flash_buf_pkg::BADDR_W-1:flash_buf_pkg::BSEL_W]]
               [wr_addr[flash_buf_pkg::BSEL_W-1:0]] <= wr_bit;
        end
    end

    // ============================================================
    // host port
    // ============================================================
    always_ff @(posedge ipb_clk) begin
        if (rd_en) begin
            rd_word <= mem[rd_addr];    // data valid one ipb_clk later
        end
    end

    // flip back so the first received bit reads as the MSB
    always_comb begin
        for (int i = 0; i < flash_buf_pkg::WORD_W; i++) begin
            rd_data[flash_buf_pkg::WORD_W-1-i] = rd_word[i];
        end
    end

    // miso must be driven whenever the response window is open
    a_wr_bit_known: assert property (@(posedge clk)
        wr_en |-> !$isunknown(wr_bit));

endmodule

/* hw/bitser_wbuf.sv */
`timescale 1ns/1ps

module bitser_wbuf (
    input  logic                              ipb_clk,
    input  logic                              wr_en,
    input  logic [flash_buf_pkg::WADDR_W-1:0] wr_addr,
    input  logic [flash_buf_pkg::WORD_W-1:0]  wr_data,
    input  logic                              clk,
    input  logic                              rd_en,
    input  logic [flash_buf_pkg::BADDR_W-1:0] rd_addr,
    output logic                              rd_bit
);

    // words are kept bit-reversed so bit 0 of each word leaves first
    logic [flash_buf_pkg::WORD_W-1:0] mem [flash_buf_pkg::NUM_WORDS];
    logic [flash_buf_pkg::WORD_W-1:0] wr_data_rev;

    always_comb begin
        for (int i = 0; i < flash_buf_pkg::WORD_W; i++) begin
            wr_data_rev[i] = wr_data[flash_buf_pkg::WORD_W-1-i];  // MSB lands in bit 0
        end
    end

    // ============================================================
    // host port
    // ============================================================
    always_ff @(posedge ipb_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data_rev;    // one full word per ipb_clk
        end
    end

    // ============================================================
    // flash port
    // ============================================================
    // upper address bits pick the word and the low 5 bits pick the bit
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_bit <= mem[rd_addr[flash_buf_pkg::BADDR_W-1:flash_buf_pkg::BSEL_W]]
                         [rd_addr[flash_buf_pkg::BSEL_W-1:0]];
        end
    end

    // sequencer must hand over a clean address inside the buffer
    a_rd_addr: assert property (@(posedge clk)
        rd_en |-> !$isunknown(rd_addr) && (rd_addr < flash_buf_pkg::NUM_BITS));

endmodule

/* hw/sync_2stage.sv */
`timescale 1ns/1ps

module sync_2stage #(
    parameter int WIDTH = 1
) (
    input  logic             clk,
    input  logic [WIDTH-1:0] in,
    output logic [WIDTH-1:0] out
);

    logic [WIDTH-1:0] meta;     // first stage, may go metastable

    // buses are only passed through here while the source holds them steady
    always_ff @(posedge clk) begin
        meta <= in;
        out  <= meta;
    end

endmodule

/* hw/flash_buf_pkg.sv */
package flash_buf_pkg;

    // ============================================================
    // WBUF / RBUF geometry
    // ============================================================
    localparam int WORD_W    = 32;                  // host word
    localparam int WADDR_W   = 7;                   // 128 words per buffer
    localparam int BADDR_W   = 12;                  // one address per bit
    localparam int BSEL_W    = BADDR_W - WADDR_W;   // bit within a word

    localparam int NUM_WORDS = 1 << WADDR_W;
    localparam int NUM_BITS  = NUM_WORDS * WORD_W;  // 4096 bits per buffer

endpackage

/* hw/flash_cmd_pkg.sv */
package flash_cmd_pkg;

    // byte count for either direction of a flash transaction (0 to 511)
    typedef logic [8:0] nbytes_t;

    // ============================================================
    // host command word, format 0x0NNN0MMM
    // ============================================================
    typedef union packed {
        logic [31:0] raw;                // whole word as the host writes it
        struct packed {
            logic [6:0] zero_wr;         // bits 31:25 unused
            nbytes_t    wr_nbytes;       // bytes to send from WBUF
            logic [6:0] zero_rd;         // bits 15:9 unused
            nbytes_t    rd_nbytes;       // response bytes to keep in RBUF
        } fields;
    } flash_cmd_u;

    // ============================================================
    // sequencer states
    // ============================================================
    // each value is a bit index into the one-hot state vector
    localparam int NUM_STATES    = 10;

    localparam int IDLE          = 0;
    localparam int START_CMD     = 1;    // ss still high, first WBUF read
    localparam int SEND_CMD      = 2;
    localparam int FINISH_CMD    = 3;
    localparam int RECEIVE_RSP   = 4;
    localparam int START_BS_CMD  = 5;
    localparam int SEND_BS_CMD   = 6;    // 4-byte read command
    localparam int FINISH_BS_CMD = 7;
    localparam int READ_BS       = 8;    // bitstream streamed out
    localparam int BS_DONE       = 9;

endpackage
